/* vlog.f */
+incdir+.
video_pkg.sv
video_ifs.sv
video_regs.sv
layer_renderer.sv
mem_arbiter.sv
line_compositor.sv
tile_video.sv
tile_video_assertions.sv
tb_tile_video.sv

/* Makefile */
all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tile_video -f vlog.f

run: compile
	./obj_dir/Vtb_tile_video +verilator+error+limit+1000 | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

/* tb_tile_video.sv */
`timescale 1ns/1ns
`include "video_defines.svh"

module tb_tile_video;
    import video_pkg::*;

    localparam int LINE_CYCLES  = 600;
    localparam int TOTAL_LINES  = 20;
    // Register sweeps, writes and idle gaps
    localparam int SPARE_CYCLES = 2000;
    localparam int WATCHDOG_NS  = (TOTAL_LINES * LINE_CYCLES + SPARE_CYCLES) * 8;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   start_of_screen;
    logic                   start_of_line;
    logic [`REG_ADDR_W-1:0] regs_addr;
    logic [7:0]             regs_wrdata;
    logic                   regs_write;
    logic [7:0]             regs_rddata;
    logic [17:0]            mem_addr;
    logic                   mem_strobe;
    logic [31:0]            mem_rddata = 32'h0;
    logic                   mem_ack    = 1'b0;
    logic [5:0]             pix_idx;
    logic                   pix_rd;
    logic [7:0]             pix_color;

    logic        mem_busy = 1'b0;
    logic [1:0]  mem_wait = 2'd0;
    logic [31:0] rng_q    = 32'h1e43f759;

    int passed       = 0;
    int failed       = 0;
    int fails_before = 0;

    tile_video dut0 (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] h;
        h = s ^ (s << 13);
        h = h ^ (h >> 17);
        h = h ^ (h << 5);
        return h;
    endfunction

    //////////////////////////////////////////////////
    // Memory model, ack after 1 to 4 cycles

    always @(negedge clk) begin
        if (mem_ack) begin
            mem_ack <= 1'b0;
        end else if (mem_busy) begin
            if (mem_wait == 2'd0) begin
                mem_ack    <= 1'b1;
                mem_rddata <= xorshift(32'h1e43f759 ^ {16'h0000, mem_addr[17:2]});
                mem_busy   <= 1'b0;
            end else begin
                mem_wait <= mem_wait - 2'd1;
            end
        end else if (mem_strobe) begin
            rng_q    <= xorshift(rng_q);
            mem_wait <= rng_q[1:0];
            mem_busy <= 1'b1;
        end
    end

    task automatic write_reg(input int layer, input int idx, input logic [7:0] data);
        @(negedge clk);
        regs_addr   = {layer[0], idx[3:0]};
        regs_wrdata = data;
        regs_write  = 1'b1;
        @(negedge clk);
        regs_write  = 1'b0;
    endtask

    task automatic sweep_regs();
        for (int a = 0; a < 32; a++) begin
            @(negedge clk);
            regs_addr = 5'(a);
        end
        @(negedge clk);
    endtask

    task automatic pulse_screen();
        @(negedge clk);
        start_of_screen = 1'b1;
        @(negedge clk);
        start_of_screen = 1'b0;
    endtask

    // One line period, reading back the line rendered before it
    task automatic run_lines(input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            start_of_line = 1'b1;
            @(negedge clk);
            start_of_line = 1'b0;
            for (int x = 0; x < `LINE_PIXELS; x++) begin
                pix_idx = 6'(x);
                pix_rd  = 1'b1;
                @(negedge clk);
            end
            pix_rd = 1'b0;
            repeat (LINE_CYCLES - `LINE_PIXELS - 2) @(negedge clk);
        end
    endtask

    task automatic end_test(input string name);
        if (dut0.checks.fails > fails_before) begin
            failed++;
            $display("%s: failed with %0d assertion errors", name,
                     dut0.checks.fails - fails_before);
        end else begin
            passed++;
            $display("%s: passed", name);
        end
        fails_before = dut0.checks.fails;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst             = 1'b1;
        start_of_screen = 1'b0;
        start_of_line   = 1'b0;
        regs_addr       = '0;
        regs_wrdata     = 8'h00;
        regs_write      = 1'b0;
        pix_idx         = 6'd0;
        pix_rd          = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        sweep_regs();
        end_test("reset values");

        // Middle control bits are dropped, unmapped indices ignored
        for (int l = 0; l < `NUM_LAYERS; l++) begin
            write_reg(l, REG_CTRL, 8'hfe);
            write_reg(l, REG_MAP_LO, 8'h5a + 8'(l));
            write_reg(l, REG_MAP_HI, 8'hc3);
            write_reg(l, REG_TILE_LO, 8'h96);
            write_reg(l, REG_TILE_HI, 8'h3c - 8'(l));
            for (int i = 5; i < 16; i++) begin
                write_reg(l, i, 8'hff);
            end
        end
        sweep_regs();
        end_test("register writes");

        write_reg(1, REG_CTRL, 8'h00);
        write_reg(0, REG_MAP_LO, 8'h00);
        write_reg(0, REG_MAP_HI, 8'h01);
        write_reg(0, REG_TILE_LO, 8'h00);
        write_reg(0, REG_TILE_HI, 8'h20);
        write_reg(0, REG_CTRL, 8'h01);
        repeat (40) @(negedge clk);
        pulse_screen();
        run_lines(1);
        end_test("bus idle until line start");

        // Crosses into the second character row
        run_lines(11);
        end_test("text16 layer 0");

        write_reg(0, REG_CTRL, 8'h21);
        pulse_screen();
        run_lines(4);
        end_test("text256 layer 0");

        write_reg(0, REG_CTRL, 8'h01);
        write_reg(1, REG_MAP_LO, 8'h00);
        write_reg(1, REG_MAP_HI, 8'h04);
        write_reg(1, REG_TILE_LO, 8'h00);
        write_reg(1, REG_TILE_HI, 8'h30);
        write_reg(1, REG_CTRL, 8'h21);
        pulse_screen();
        run_lines(4);
        end_test("two layers merged");

        $display("%0d tests passed, %0d failed", passed, failed);
        if (failed == 0 && dut0.checks.fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tile_video_assertions.sv */
`timescale 1ns/1ns
`include "video_defines.svh"

module tile_video_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   start_of_screen,
    input logic                   start_of_line,
    input logic [`REG_ADDR_W-1:0] regs_addr,
    input logic [7:0]             regs_wrdata,
    input logic                   regs_write,
    input logic [7:0]             regs_rddata,
    input logic [17:0]            mem_addr,
    input logic                   mem_strobe,
    input logic                   mem_ack,
    input logic [5:0]             pix_idx,
    input logic                   pix_rd,
    input logic [7:0]             pix_color
);
    import video_pkg::*;

    localparam int NL = `NUM_LAYERS;

    int fails = 0;

    // Register mirror
    logic [7:0]  ctrl_m [NL];
    logic [15:0] map_m  [NL];
    logic [15:0] tile_m [NL];

    // Setup of the line being rendered and of the line on display
    logic [7:0]  ren_ctrl [NL];
    logic [15:0] ren_tile [NL];
    logic [15:0] ren_row  [NL];
    logic [2:0]  ren_line [NL];
    logic [7:0]  shw_ctrl [NL];
    logic [15:0] shw_tile [NL];
    logic [15:0] shw_row  [NL];
    logic [2:0]  shw_line [NL];
    logic        ren_valid;
    logic        shw_valid;

    logic [15:0] row_ptr [NL];
    logic [2:0]  line_cnt;
    logic        armed;
    logic [7:0]  exp_rd;
    logic [7:0]  exp_pix;
    logic [7:0]  exp_pix_q;

    // Memory contents, same hash as the memory model
    function automatic logic [31:0] mem_word(logic [15:0] waddr);
        logic [31:0] h;
        h = 32'h1e43f759 ^ {16'h0000, waddr};
        h = h ^ (h << 13);
        h = h ^ (h >> 17);
        h = h ^ (h << 5);
        return h;
    endfunction

    function automatic logic [7:0] layer_pixel(logic [7:0] ctrl, logic [15:0] tile_base,
                                               logic [15:0] row, logic [2:0] line,
                                               logic [5:0] x);
        logic [31:0] map_word;
        logic [15:0] entry;
        logic [17:0] byte_addr;
        logic [31:0] tile_word;
        logic [7:0]  row_bits;
        logic        bit_set;
        if (!ctrl[0]) begin
            return 8'h00;
        end
        // Two characters per map word, low half first
        map_word  = mem_word(row + 16'(x[5:4]));
        entry     = x[3] ? map_word[31:16] : map_word[15:0];
        byte_addr = {tile_base, 2'b00} + {7'b0000000, entry[7:0], line};
        tile_word = mem_word(byte_addr[17:2]);
        row_bits  = tile_word[{byte_addr[1:0], 3'b000} +: 8];
        bit_set   = row_bits[3'd7 - x[2:0]];
        if (ctrl[7:5] == MODE_TEXT256) begin
            return bit_set ? entry[15:8] : 8'h00;
        end
        return bit_set ? {4'h0, entry[11:8]} : {4'h0, entry[15:12]};
    endfunction

    //////////////////////////////////////////////////
    // Mirror of registers and line sequencing

    always_ff @(posedge clk or posedge rst) begin
        logic [15:0] base;
        logic [2:0]  ln;
        if (rst) begin
            for (int g = 0; g < NL; g++) begin
                ctrl_m[g]   <= 8'h00;
                map_m[g]    <= 16'h0000;
                tile_m[g]   <= 16'h8000;
                row_ptr[g]  <= 16'h0000;
                ren_ctrl[g] <= 8'h00;
                ren_tile[g] <= 16'h0000;
                ren_row[g]  <= 16'h0000;
                ren_line[g] <= 3'd0;
            end
            line_cnt  <= 3'd0;
            ren_valid <= 1'b0;
            shw_valid <= 1'b0;
            armed     <= 1'b0;
        end else begin
            if (regs_write) begin
                case (regs_addr[3:0])
                    REG_CTRL: begin
                        ctrl_m[regs_addr[4]] <= {regs_wrdata[7:5], 4'b0000, regs_wrdata[0]};
                    end
                    REG_MAP_LO:  map_m[regs_addr[4]][7:0]   <= regs_wrdata;
                    REG_MAP_HI:  map_m[regs_addr[4]][15:8]  <= regs_wrdata;
                    REG_TILE_LO: tile_m[regs_addr[4]][7:0]  <= regs_wrdata;
                    REG_TILE_HI: tile_m[regs_addr[4]][15:8] <= regs_wrdata;
                    default: ;
                endcase
            end
            ln = start_of_screen ? 3'd0 : line_cnt;
            if (start_of_line) begin
                for (int g = 0; g < NL; g++) begin
                    base = start_of_screen ? map_m[g] : row_ptr[g];
                    shw_ctrl[g] <= ren_ctrl[g];
                    shw_tile[g] <= ren_tile[g];
                    shw_row[g]  <= ren_row[g];
                    shw_line[g] <= ren_line[g];
                    ren_ctrl[g] <= ctrl_m[g];
                    ren_tile[g] <= tile_m[g];
                    ren_row[g]  <= base;
                    ren_line[g] <= ln;
                    // Next character row after eight lines
                    row_ptr[g]  <= (ln == 3'd7) ? base + 16'(`MAP_ROW_WORDS) : base;
                    if (ctrl_m[g][0]) begin
                        armed <= 1'b1;
                    end
                end
                line_cnt  <= ln + 3'd1;
                ren_valid <= 1'b1;
                shw_valid <= ren_valid;
            end else if (start_of_screen) begin
                line_cnt <= 3'd0;
                for (int g = 0; g < NL; g++) begin
                    row_ptr[g] <= map_m[g];
                end
            end
        end
    end

    always_comb begin
        case (regs_addr[3:0])
            REG_CTRL:    exp_rd = ctrl_m[regs_addr[4]];
            REG_MAP_LO:  exp_rd = map_m[regs_addr[4]][7:0];
            REG_MAP_HI:  exp_rd = map_m[regs_addr[4]][15:8];
            REG_TILE_LO: exp_rd = tile_m[regs_addr[4]][7:0];
            REG_TILE_HI: exp_rd = tile_m[regs_addr[4]][15:8];
            default:     exp_rd = 8'h00;
        endcase
    end

    // Upper layer shows through wherever it is non-zero
    always_comb begin
        logic [7:0] c;
        exp_pix = 8'h00;
        for (int g = 0; g < NL; g++) begin
            c = layer_pixel(shw_ctrl[g], shw_tile[g], shw_row[g], shw_line[g], pix_idx);
            if (g == 0 || c != 8'h00) begin
                exp_pix = c;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_rd) begin
            exp_pix_q <= exp_pix;
        end
    end

    //////////////////////////////////////////////////
    // Checks

    assert property (@(posedge clk) disable iff (rst) regs_rddata == exp_rd)
        else begin
            fails++;
            $error("regs_rddata at %h got %h expected %h", $sampled(regs_addr),
                   $sampled(regs_rddata), $sampled(exp_rd));
        end

    assert property (@(posedge clk) disable iff (rst)
                     pix_rd && shw_valid |=> pix_color == exp_pix_q)
        else begin
            fails++;
            $error("pix_color got %h expected %h", $sampled(pix_color), $sampled(exp_pix_q));
        end

    assert property (@(posedge clk) disable iff (rst) mem_ack |-> !mem_strobe)
        else begin
            fails++;
            $error("mem_strobe high in the ack cycle");
        end

    assert property (@(posedge clk) disable iff (rst)
                     mem_strobe |=> $stable(mem_addr) && (mem_strobe || mem_ack))
        else begin
            fails++;
            $error("mem_strobe dropped or mem_addr changed before ack, mem_addr %h",
                   $sampled(mem_addr));
        end

    assert property (@(posedge clk) disable iff (rst) !armed |-> !mem_strobe)
        else begin
            fails++;
            $error("mem_strobe raised before a line start with a layer enabled");
        end

    assert property (@(posedge clk) $fell(rst) |-> !mem_strobe && pix_color == 8'h00)
        else begin
            fails++;
            $error("outputs not idle after reset, pix_color %h", $sampled(pix_color));
        end

endmodule

bind tile_video tile_video_assertions checks (
    .clk             (clk),
    .rst             (rst),
    .start_of_screen (start_of_screen),
    .start_of_line   (start_of_line),
    .regs_addr       (regs_addr),
    .regs_wrdata     (regs_wrdata),
    .regs_write      (regs_write),
    .regs_rddata     (regs_rddata),
    .mem_addr        (mem_addr),
    .mem_strobe      (mem_strobe),
    .mem_ack         (mem_ack),
    .pix_idx         (pix_idx),
    .pix_rd          (pix_rd),
    .pix_color       (pix_color)
);

/* tile_video.sv */
`timescale 1ns/1ns
`include "video_defines.svh"

module tile_video (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_of_screen,
    input  logic                   start_of_line,
    input  logic [`REG_ADDR_W-1:0] regs_addr,
    input  logic [7:0]             regs_wrdata,
    input  logic                   regs_write,
    output logic [7:0]             regs_rddata,
    output logic [17:0]            mem_addr,
    output logic                   mem_strobe,
    input  logic [31:0]            mem_rddata,
    input  logic                   mem_ack,
    input  logic [5:0]             pix_idx,
    input  logic                   pix_rd,
    output logic [7:0]             pix_color
);
    layer_cfg_if cfg [`NUM_LAYERS] ();
    mem_bus_if   bus [`NUM_LAYERS] ();

    logic [5:0] wr_idx  [`NUM_LAYERS];
    logic [7:0] wr_data [`NUM_LAYERS];
    logic       wr_en   [`NUM_LAYERS];

    video_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .regs_addr   (regs_addr),
        .regs_wrdata (regs_wrdata),
        .regs_write  (regs_write),
        .regs_rddata (regs_rddata),
        .cfg         (cfg)
    );

    //////////////////////////////////////////////////
    // One renderer per layer

    for (genvar g = 0; g < `NUM_LAYERS; g++) begin : g_layer
        layer_renderer u_renderer (
            .clk             (clk),
            .rst             (rst),
            .start_of_screen (start_of_screen),
            .start_of_line   (start_of_line),
            .cfg             (cfg[g]),
            .bus             (bus[g]),
            .wr_idx          (wr_idx[g]),
            .wr_data         (wr_data[g]),
            .wr_en           (wr_en[g])
        );
    end

    mem_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .lyr        (bus),
        .mem_addr   (mem_addr),
        .mem_strobe (mem_strobe),
        .mem_rddata (mem_rddata),
        .mem_ack    (mem_ack)
    );

    line_compositor u_compositor (
        .clk           (clk),
        .rst           (rst),
        .start_of_line (start_of_line),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .wr_en         (wr_en),
        .pix_idx       (pix_idx),
        .pix_rd        (pix_rd),
        .pix_color     (pix_color)
    );

endmodule

/* line_compositor.sv */
`timescale 1ns/1ns
`include "video_defines.svh"

module line_compositor (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_of_line,
    input  logic [5:0] wr_idx [`NUM_LAYERS],
    input  logic [7:0] wr_data [`NUM_LAYERS],
    input  logic       wr_en [`NUM_LAYERS],
    input  logic [5:0] pix_idx,
    input  logic       pix_rd,
    output logic [7:0] pix_color
);
    // Renderers fill bank_q while the display reads the other bank
    logic       bank_q;
    logic [7:0] rd_color [`NUM_LAYERS];
    logic [7:0] merged;

    for (genvar g = 0; g < `NUM_LAYERS; g++) begin : g_buf
        logic [7:0] mem [2][`LINE_PIXELS];

        always_ff @(posedge clk) begin
            if (wr_en[g]) begin
                mem[bank_q][wr_idx[g]] <= wr_data[g];
            end
        end

        assign rd_color[g] = mem[~bank_q][pix_idx];
    end

    // Higher layer wins wherever it is non-zero
    always_comb begin
        merged = rd_color[0];
        for (int i = 1; i < `NUM_LAYERS; i++) begin
            if (rd_color[i] != 8'h00) begin
                merged = rd_color[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_q    <= 1'b0;
            pix_color <= 8'h00;
        end else begin
            if (start_of_line) begin
                bank_q <= ~bank_q;
            end
            if (pix_rd) begin
                pix_color <= merged;
            end
        end
    end

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ns
`include "video_defines.svh"

module mem_arbiter (
    input  logic        clk,
    input  logic        rst,
    mem_bus_if.slave    lyr [`NUM_LAYERS],
    output logic [17:0] mem_addr,
    output logic        mem_strobe,
    input  logic [31:0] mem_rddata,
    input  logic        mem_ack
);
    localparam int OW = $clog2(`NUM_LAYERS);

    logic          req [`NUM_LAYERS];
    logic [17:0]   req_addr [`NUM_LAYERS];
    logic          busy_q;
    logic [OW-1:0] owner_q;
    logic [OW-1:0] last_q;
    logic [OW-1:0] pick;
    logic          found;

    for (genvar g = 0; g < `NUM_LAYERS; g++) begin : g_port
        logic owned;

        assign owned          = busy_q && owner_q == OW'(g);
        assign req[g]         = lyr[g].strobe;
        assign req_addr[g]    = lyr[g].addr;
        assign lyr[g].ack     = owned && mem_ack;
        assign lyr[g].rddata  = owned ? mem_rddata : 32'h0;
    end

    // First requester after the last one served
    always_comb begin
        int cand;
        pick  = last_q;
        found = 1'b0;
        for (int i = 1; i <= `NUM_LAYERS; i++) begin
            cand = (int'(last_q) + i) % `NUM_LAYERS;
            if (!found && req[cand]) begin
                pick  = OW'(cand);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q  <= 1'b0;
            owner_q <= '0;
            last_q  <= OW'(`NUM_LAYERS - 1);
        end else if (busy_q) begin
            if (mem_ack) begin
                busy_q <= 1'b0;
                last_q <= owner_q;
            end
        end else if (found) begin
            busy_q  <= 1'b1;
            owner_q <= pick;
        end
    end

    assign mem_strobe = busy_q && req[owner_q];
    assign mem_addr   = req_addr[owner_q];

endmodule

/* layer_renderer.sv */
`timescale 1ns/1ns
`include "video_defines.svh"

module layer_renderer (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_of_screen,
    input  logic        start_of_line,
    layer_cfg_if.layer  cfg,
    mem_bus_if.master   bus,
    output logic [5:0]  wr_idx,
    output logic [7:0]  wr_data,
    output logic        wr_en
);
    import video_pkg::*;

    typedef enum logic [2:0] {
        ST_WAIT,
        ST_FETCH_MAP,
        ST_WAIT_MAP,
        ST_FETCH_TILE,
        ST_WAIT_TILE,
        ST_RENDER
    } state_t;

    localparam logic [5:0] LAST_X = 6'(`LINE_PIXELS - 1);

    state_t      state_q;
    logic        strobe_q;
    logic [17:0] addr_q;
    logic        line_en_q;

    // Map position: start of current character row and next word to fetch
    logic [15:0] map_row_q;
    logic [15:0] map_addr_q;

    // Line within the character row, and the one the next line will use
    logic [2:0]  line_q;
    logic [2:0]  next_line_q;
    logic [5:0]  x_q;

    logic [31:0] map_word_q;
    logic [31:0] tile_word_q;

    logic [15:0] row_base;
    logic [2:0]  line_next;
    logic [17:0] tile_addr;
    map_entry_t  entry;
    logic [7:0]  tile_byte;
    logic        pix_bit;
    logic [7:0]  pix_color;

    //////////////////////////////////////////////////
    // Pixel decode

    always_comb begin
        entry     = x_q[3] ? map_word_q[31:16] : map_word_q[15:0];
        tile_byte = tile_word_q[{line_q[1:0], 3'b000} +: 8];
        // MSB is the leftmost pixel
        pix_bit   = tile_byte[3'd7 - x_q[2:0]];
        if (!line_en_q) begin
            pix_color = 8'h00;
        end else if (cfg.mode == MODE_TEXT256) begin
            pix_color = pix_bit ? entry.text256.color : 8'h00;
        end else begin
            pix_color = pix_bit ? {4'h0, entry.text16.fg} : {4'h0, entry.text16.bg};
        end
    end

    // Eight bytes per tile, bit 2 of the line picks the word
    assign tile_addr = {cfg.tile_base, 2'b00} + 18'({entry.text16.tile_idx, line_q[2], 2'b00});

    // A frame start in the same cycle counts as line 0 of the map base
    assign row_base  = start_of_screen ? cfg.map_base : map_row_q;
    assign line_next = start_of_screen ? 3'd0 : next_line_q;

    assign bus.addr   = addr_q;
    assign bus.strobe = strobe_q && !bus.ack;

    //////////////////////////////////////////////////
    // Fetch and render FSM

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= ST_WAIT;
            strobe_q    <= 1'b0;
            wr_en       <= 1'b0;
            line_en_q   <= 1'b0;
            x_q         <= 6'd0;
            line_q      <= 3'd0;
            next_line_q <= 3'd0;
            map_row_q   <= 16'h0000;
            map_addr_q  <= 16'h0000;
        end else begin
            wr_en <= 1'b0;
            case (state_q)
                ST_FETCH_MAP: begin
                    strobe_q   <= 1'b1;
                    map_addr_q <= map_addr_q + 16'd1;
                    state_q    <= ST_WAIT_MAP;
                end
                ST_WAIT_MAP: begin
                    if (bus.ack) begin
                        strobe_q <= 1'b0;
                        state_q  <= ST_FETCH_TILE;
                    end
                end
                ST_FETCH_TILE: begin
                    strobe_q <= 1'b1;
                    state_q  <= ST_WAIT_TILE;
                end
                ST_WAIT_TILE: begin
                    if (bus.ack) begin
                        strobe_q <= 1'b0;
                        state_q  <= ST_RENDER;
                    end
                end
                ST_RENDER: begin
                    wr_en <= 1'b1;
                    x_q   <= x_q + 6'd1;
                    if (x_q == LAST_X) begin
                        state_q <= ST_WAIT;
                    end else if (x_q[2:0] == 3'd7 && line_en_q) begin
                        // Both halves of a map word used, fetch the next word
                        state_q <= x_q[3] ? ST_FETCH_MAP : ST_FETCH_TILE;
                    end
                end
                default: ;
            endcase

            if (start_of_line) begin
                state_q     <= cfg.enable ? ST_FETCH_MAP : ST_RENDER;
                line_en_q   <= cfg.enable;
                x_q         <= 6'd0;
                line_q      <= line_next;
                next_line_q <= line_next + 3'd1;
                map_addr_q  <= row_base;
                map_row_q   <= (line_next == 3'd7) ? row_base + 16'(`MAP_ROW_WORDS) : row_base;
            end else if (start_of_screen) begin
                next_line_q <= 3'd0;
                map_row_q   <= cfg.map_base;
                map_addr_q  <= cfg.map_base;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_FETCH_MAP) begin
            addr_q <= {map_addr_q, 2'b00};
        end
        if (state_q == ST_FETCH_TILE) begin
            addr_q <= tile_addr;
        end
        if (state_q == ST_WAIT_MAP && bus.ack) begin
            map_word_q <= bus.rddata;
        end
        if (state_q == ST_WAIT_TILE && bus.ack) begin
            tile_word_q <= bus.rddata;
        end
        if (state_q == ST_RENDER) begin
            wr_idx  <= x_q;
            wr_data <= pix_color;
        end
    end

endmodule

/* video_regs.sv */
`timescale 1ns/1ns
`include "video_defines.svh"

module video_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] regs_addr,
    input  logic [7:0]             regs_wrdata,
    input  logic                   regs_write,
    output logic [7:0]             regs_rddata,
    layer_cfg_if.regs              cfg [`NUM_LAYERS]
);
    import video_pkg::*;

    reg_index_t idx;
    logic [7:0] rd_byte [`NUM_LAYERS];

    assign idx = reg_index_t'(regs_addr[3:0]);

    for (genvar g = 0; g < `NUM_LAYERS; g++) begin : g_layer
        logic        enable_q;
        layer_mode_t mode_q;
        logic [15:0] map_base_q;
        logic [15:0] tile_base_q;
        logic [7:0]  rd;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                enable_q    <= 1'b0;
                mode_q      <= MODE_TEXT16;
                map_base_q  <= 16'h0000;
                tile_base_q <= 16'h8000;
            end else if (regs_write && regs_addr[4] == 1'(g)) begin
                case (idx)
                    REG_CTRL: begin
                        mode_q   <= layer_mode_t'(regs_wrdata[7:5]);
                        enable_q <= regs_wrdata[0];
                    end
                    REG_MAP_LO:  map_base_q[7:0]   <= regs_wrdata;
                    REG_MAP_HI:  map_base_q[15:8]  <= regs_wrdata;
                    REG_TILE_LO: tile_base_q[7:0]  <= regs_wrdata;
                    REG_TILE_HI: tile_base_q[15:8] <= regs_wrdata;
                    default: ;
                endcase
            end
        end

        // Readback, unmapped indices give 0
        always_comb begin
            case (idx)
                REG_CTRL:    rd = {mode_q, 4'b0000, enable_q};
                REG_MAP_LO:  rd = map_base_q[7:0];
                REG_MAP_HI:  rd = map_base_q[15:8];
                REG_TILE_LO: rd = tile_base_q[7:0];
                REG_TILE_HI: rd = tile_base_q[15:8];
                default:     rd = 8'h00;
            endcase
        end

        assign rd_byte[g]        = rd;
        assign cfg[g].enable    = enable_q;
        assign cfg[g].mode      = mode_q;
        assign cfg[g].map_base  = map_base_q;
        assign cfg[g].tile_base = tile_base_q;
    end

    assign regs_rddata = rd_byte[regs_addr[4]];

endmodule

/* video_ifs.sv */
`timescale 1ns/1ns

// Static per-layer configuration levels
interface layer_cfg_if;
    import video_pkg::*;

    logic        enable;
    layer_mode_t mode;
    logic [15:0] map_base;
    logic [15:0] tile_base;

    modport regs (
        output enable,
        output mode,
        output map_base,
        output tile_base
    );

    modport layer (
        input enable,
        input mode,
        input map_base,
        input tile_base
    );
endinterface

// Strobe/ack read bus, one request in flight
interface mem_bus_if;
    logic [17:0] addr;
    logic [31:0] rddata;
    logic        strobe;
    logic        ack;

    modport master (
        output addr,
        output strobe,
        input  rddata,
        input  ack
    );

    modport slave (
        input  addr,
        input  strobe,
        output rddata,
        output ack
    );
endinterface

/* video_pkg.sv */
package video_pkg;

    // One map half-word seen as a 16-colour text character
    typedef struct packed {
        logic [3:0] bg;
        logic [3:0] fg;
        logic [7:0] tile_idx;
    } text16_entry_t;

    // Same half-word seen as a 256-colour text character
    typedef struct packed {
        logic [7:0] color;
        logic [7:0] tile_idx;
    } text256_entry_t;

    typedef union packed {
        text16_entry_t  text16;
        text256_entry_t text256;
    } map_entry_t;

    typedef enum logic [2:0] {
        MODE_TEXT16  = 3'd0,
        MODE_TEXT256 = 3'd1
    } layer_mode_t;

    typedef enum logic [3:0] {
        REG_CTRL,
        REG_MAP_LO,
        REG_MAP_HI,
        REG_TILE_LO,
        REG_TILE_HI
    } reg_index_t;

endpackage

/* video_defines.svh */
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Number of layer renderers
`define NUM_LAYERS 2

// Pixels per rendered line
`define LINE_PIXELS 64

// Map words from one character row to the next
`define MAP_ROW_WORDS 32

// Register address, layer select in the top bit
`define REG_ADDR_W 5

`endif
